// File: Makefile
# Verilator build of the trap unit testbench

TOP := trap_unit_tb

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

// File: files.f
hw/csr_pkg.sv
hw/trap_pkg.sv
hw/csr_file.sv
hw/trap_ctrl.sv
hw/trap_unit_top.sv
test/trap_unit_assert.sv
test/trap_unit_tb.sv

// File: hw/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file
   import csr_pkg::*, trap_pkg::*;
(
   input  logic            clk_i,
   input  logic            e_intr,
   input  csr_req_t        csr_req_i,
   input  logic            ext_irq_i,
   input  logic [XLEN-1:0] pc_i,
   input  trap_upd_t       trap_upd_i,
   output logic [XLEN-1:0] csr_rdata_o,
   output csr_state_t      csr_state_o
);

   logic [XLEN-1:0] mstatus;
   logic [XLEN-1:0] mie;
   mtvec_u          mtvec;
   logic [XLEN-1:0] mepc;
   logic [XLEN-1:0] mcause;
   logic [XLEN-1:0] mip;

   logic wr_mstatus;
   logic wr_mie;
   logic wr_mtvec;
   logic wr_mepc;
   logic wr_mcause;

   // write decode
   always_comb begin
      wr_mstatus = 1'b0;
      wr_mie     = 1'b0;
      wr_mtvec   = 1'b0;
      wr_mepc    = 1'b0;
      wr_mcause  = 1'b0;
      if (csr_req_i.we) begin
         case (csr_req_i.addr)
            CSR_MSTATUS: wr_mstatus = 1'b1;
            CSR_MIE:     wr_mie     = 1'b1;
            CSR_MTVEC:   wr_mtvec   = 1'b1;
            CSR_MEPC:    wr_mepc    = 1'b1;
            CSR_MCAUSE:  wr_mcause  = 1'b1;
            default:     ;  // mip is read only
         endcase
      end
   end

   always_comb begin
      case (csr_req_i.addr)
         CSR_MSTATUS: csr_rdata_o = mstatus;
         CSR_MIE:     csr_rdata_o = mie;
         CSR_MTVEC:   csr_rdata_o = mtvec.raw;
         CSR_MEPC:    csr_rdata_o = mepc;
         CSR_MCAUSE:  csr_rdata_o = mcause;
         CSR_MIP:     csr_rdata_o = mip;
         default:     csr_rdata_o = '0;
      endcase
   end

   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         mstatus <= '0;
      end else begin
         if (wr_mstatus) begin
            mstatus <= csr_req_i.wdata;
         end
         // later assignments win, so trap bits override the sw write
         if (trap_upd_i.take) begin
            mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
            mstatus[MSTATUS_MIE]  <= 1'b0;
         end else if (trap_upd_i.ret) begin
            mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
            mstatus[MSTATUS_MPIE] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         mie   <= '0;
         mtvec <= '0;
      end else begin
         if (wr_mie) mie <= csr_req_i.wdata;
         if (wr_mtvec) mtvec.raw <= csr_req_i.wdata;
      end
   end

   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         mepc   <= '0;
         mcause <= '0;
      end else if (trap_upd_i.take) begin
         mepc   <= pc_i;  // interrupted instruction
         mcause <= CAUSE_MEI;
      end else begin
         if (wr_mepc) mepc <= csr_req_i.wdata;
         if (wr_mcause) mcause <= csr_req_i.wdata;
      end
   end

   // only MEIP is live, the rest stays zero
   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         mip <= '0;
      end else begin
         mip[MIP_MEIP] <= ext_irq_i;
      end
   end

   assign csr_state_o.mie_bit = mstatus[MSTATUS_MIE];
   assign csr_state_o.meie    = mie[MIE_MEIE];
   assign csr_state_o.meip    = mip[MIP_MEIP];
   assign csr_state_o.mtvec   = mtvec;
   assign csr_state_o.mepc    = mepc;

endmodule

`default_nettype wire

// File: hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

   localparam int XLEN = 32;

   // machine csr addresses
   localparam logic [11:0] CSR_MSTATUS = 12'h300;
   localparam logic [11:0] CSR_MIE     = 12'h304;
   localparam logic [11:0] CSR_MTVEC   = 12'h305;
   localparam logic [11:0] CSR_MEPC    = 12'h341;
   localparam logic [11:0] CSR_MCAUSE  = 12'h342;
   localparam logic [11:0] CSR_MIP     = 12'h344;

   localparam int MSTATUS_MIE  = 3;
   localparam int MSTATUS_MPIE = 7;
   localparam int MIE_MEIE     = 11;  // external irq enable in mie
   localparam int MIP_MEIP     = 11;  // external irq pending in mip

   // machine external interrupt, interrupt flag in the top bit
   localparam logic [XLEN-2:0] MEI_CODE  = (XLEN-1)'(11);
   localparam logic [XLEN-1:0] CAUSE_MEI = {1'b1, MEI_CODE};

   localparam logic [1:0] MTVEC_DIRECT   = 2'd0;
   localparam logic [1:0] MTVEC_VECTORED = 2'd1;

   typedef struct packed {
      logic [XLEN-3:0] base;  // word aligned
      logic [1:0]      mode;
   } mtvec_fields_t;

   // csr bus sees raw, trap logic sees base and mode
   typedef union packed {
      logic [XLEN-1:0] raw;
      mtvec_fields_t   f;
   } mtvec_u;

endpackage

`default_nettype wire

// File: hw/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl
   import csr_pkg::*, trap_pkg::*;
#(
   parameter int unsigned REDIRECT_CREDITS = 2
) (
   input  logic            clk_i,
   input  logic            e_intr,
   input  logic            mret_i,
   input  logic            credit_return_i,
   input  csr_state_t      csr_state_i,
   input  logic [XLEN-1:0] pc_i,
   output trap_upd_t       trap_upd_o,
   output redirect_t       redirect_o
);

   localparam int unsigned CW = $clog2(REDIRECT_CREDITS + 1);
   // vectored entry is base + 4 * cause code
   localparam logic [XLEN-1:0] VEC_OFFSET = XLEN'(MEI_CODE) << 2;

   logic [CW-1:0]   credit_cnt;
   logic            have_credit;
   logic            mret_pend;
   logic            irq_ready;
   logic            take;
   logic            ret;
   logic            issue;
   logic [XLEN-1:0] base_addr;
   logic [XLEN-1:0] irq_target;
   logic            valid_q;
   logic [XLEN-1:0] target_q;

   assign have_credit = (credit_cnt != '0);
   assign irq_ready   = csr_state_i.meip & csr_state_i.mie_bit & csr_state_i.meie;

   // pending mret has priority over the interrupt
   assign ret   = mret_pend & have_credit;
   assign take  = irq_ready & ~mret_pend & have_credit;
   assign issue = take | ret;

   assign trap_upd_o = '{take: take, ret: ret, epc: pc_i};

   assign base_addr = {csr_state_i.mtvec.f.base, 2'b00};

   always_comb begin
      case (csr_state_i.mtvec.f.mode)
         MTVEC_DIRECT:   irq_target = base_addr;
         MTVEC_VECTORED: irq_target = base_addr + VEC_OFFSET;
         default:        irq_target = base_addr;  // reserved modes act direct
      endcase
   end

   // one credit per redirect, spent at the issue edge
   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         credit_cnt <= CW'(REDIRECT_CREDITS);
      end else if (issue && !credit_return_i) begin
         credit_cnt <= credit_cnt - CW'(1);
      end else if (!issue && credit_return_i) begin
         credit_cnt <= credit_cnt + CW'(1);
      end
   end

   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         mret_pend <= 1'b0;
      end else if (mret_i) begin
         mret_pend <= 1'b1;
      end else if (ret) begin
         mret_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= issue;  // high for exactly one cycle
      end
   end

   always_ff @(posedge clk_i) begin
      if (issue) begin
         target_q <= ret ? csr_state_i.mepc : irq_target;
      end
   end

   assign redirect_o = '{valid: valid_q, target: target_q};

endmodule

`default_nettype wire

// File: hw/trap_pkg.sv
`default_nettype none

package trap_pkg;

   import csr_pkg::*;

   // csr access from the core, one per cycle
   typedef struct packed {
      logic            we;
      logic [11:0]     addr;
      logic [XLEN-1:0] wdata;
   } csr_req_t;

   typedef struct packed {
      logic            mie_bit;  // mstatus.MIE
      logic            meie;
      logic            meip;
      mtvec_u          mtvec;
      logic [XLEN-1:0] mepc;
   } csr_state_t;

   typedef struct packed {
      logic            take;
      logic            ret;
      logic [XLEN-1:0] epc;
   } trap_upd_t;

   typedef struct packed {
      logic            valid;
      logic [XLEN-1:0] target;
   } redirect_t;

endpackage

`default_nettype wire

// File: hw/trap_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module trap_unit_top
   import csr_pkg::*, trap_pkg::*;
#(
   parameter int unsigned REDIRECT_CREDITS = 2
) (
   input  logic            clk_i,
   input  logic            e_intr,
   input  csr_req_t        csr_req_i,
   output logic [XLEN-1:0] csr_rdata_o,
   input  logic [XLEN-1:0] pc_i,
   input  logic            ext_irq_i,
   input  logic            mret_i,
   input  logic            credit_return_i,
   output redirect_t       redirect_o
);

   csr_state_t csr_state;
   trap_upd_t  trap_upd;

   csr_file u_csr_file (
      .clk_i       (clk_i),
      .e_intr      (e_intr),
      .csr_req_i   (csr_req_i),
      .ext_irq_i   (ext_irq_i),
      .pc_i        (pc_i),
      .trap_upd_i  (trap_upd),
      .csr_rdata_o (csr_rdata_o),
      .csr_state_o (csr_state)
   );

   // redirect credits are sized by the fetch queue
   trap_ctrl #(
      .REDIRECT_CREDITS (REDIRECT_CREDITS)
   ) u_trap_ctrl (
      .clk_i           (clk_i),
      .e_intr          (e_intr),
      .mret_i          (mret_i),
      .credit_return_i (credit_return_i),
      .csr_state_i     (csr_state),
      .pc_i            (pc_i),
      .trap_upd_o      (trap_upd),
      .redirect_o      (redirect_o)
   );

endmodule

`default_nettype wire

// File: test/trap_unit_assert.sv
`timescale 1ns/1ps
`default_nettype none

module trap_unit_assert #(
   parameter int unsigned REDIRECT_CREDITS = 2
) (
   input logic                                   clk_i,
   input logic                                   e_intr,
   input logic [$clog2(REDIRECT_CREDITS + 1)-1:0] credit_cnt_i,
   input logic                                   valid_i,
   input logic                                   take_i,
   input logic                                   ret_i
);

   localparam int unsigned CW = $clog2(REDIRECT_CREDITS + 1);

   credit_max: assert property (@(posedge clk_i) disable iff (e_intr)
      credit_cnt_i <= CW'(REDIRECT_CREDITS))
      else $error("credit count above REDIRECT_CREDITS");

   // valid comes one edge after the issue, so look at the count before it
   no_credit_issue: assert property (@(posedge clk_i) disable iff (e_intr)
      valid_i |-> $past(credit_cnt_i) != '0)
      else $error("redirect issued with no credit left");

   one_event: assert property (@(posedge clk_i) disable iff (e_intr)
      !(take_i && ret_i))
      else $error("take and ret high in the same cycle");

endmodule

`default_nettype wire

// File: test/trap_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module trap_unit_tb
   import csr_pkg::*, trap_pkg::*;
;

   localparam int              WAIT_MAX   = 12;  // cycles to wait for a redirect
   localparam int              RETURN_GAP = 2;
   localparam logic [XLEN-1:0] MIE_BIT    = 32'd1 << MSTATUS_MIE;
   localparam logic [XLEN-1:0] MPIE_BIT   = 32'd1 << MSTATUS_MPIE;
   localparam logic [XLEN-1:0] MEIE_BIT   = 32'd1 << MIE_MEIE;
   localparam logic [XLEN-1:0] VEC_STEP   = 32'd4 * 32'd11;  // vectored entry of code 11
   localparam logic [XLEN-1:0] EXT_CAUSE  = {1'b1, 31'd11};  // interrupt flag plus code 11

   typedef enum logic [2:0] {OP_WR, OP_RD, OP_IRQ, OP_MRET, OP_REL} op_e;

   typedef struct packed {
      op_e             op;
      logic [11:0]     addr;
      logic [XLEN-1:0] data;  // write data, or pc for irq
      logic [XLEN-1:0] exp;   // read value or redirect target
      logic            hold;  // fetch keeps its credits
      logic            fire;  // redirect expected
   } row_t;

   logic            clk_i = 1'b0;
   logic            e_intr;
   csr_req_t        csr_req_i;
   logic [XLEN-1:0] csr_rdata_o;
   logic [XLEN-1:0] pc_i;
   logic            ext_irq_i;
   logic            mret_i;
   logic            credit_return_i = 1'b0;
   redirect_t       redirect_o;

   row_t            tbl[$];
   logic            withhold;
   int              owed = 0;
   int              gap = 0;
   int              cycles = 0;
   logic [XLEN-1:0] pc_a, pc_b, pc_c, base_a, base_b, r1, r2;

   trap_unit_top #(
      .REDIRECT_CREDITS (2)
   ) u_trap_unit_top (
      .clk_i           (clk_i),
      .e_intr          (e_intr),
      .csr_req_i       (csr_req_i),
      .csr_rdata_o     (csr_rdata_o),
      .pc_i            (pc_i),
      .ext_irq_i       (ext_irq_i),
      .mret_i          (mret_i),
      .credit_return_i (credit_return_i),
      .redirect_o      (redirect_o)
   );

   bind trap_ctrl trap_unit_assert #(
      .REDIRECT_CREDITS (REDIRECT_CREDITS)
   ) u_trap_unit_assert (
      .clk_i        (clk_i),
      .e_intr       (e_intr),
      .credit_cnt_i (credit_cnt),
      .valid_i      (valid_q),
      .take_i       (take),
      .ret_i        (ret)
   );

   always #20 clk_i = ~clk_i;

   // fetch model handing back one credit per redirect after a short gap
   always @(negedge clk_i) begin
      credit_return_i = 1'b0;
      if (redirect_o.valid) owed = owed + 1;
      if (withhold || owed == 0) begin
         gap = 0;
      end else if (gap == RETURN_GAP) begin
         credit_return_i = 1'b1;
         owed = owed - 1;
         gap = 0;
      end else begin
         gap = gap + 1;
      end
   end

   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (tbl.size() != 0 && cycles > 20 * tbl.size()) begin
         $display("Timeout: the tests did not finish within %0d cycles", 20 * tbl.size());
         $display("RESULT: FAIL");
         $fatal(1, "timeout");
      end
   end

   task automatic report_error(input string msg);
      $display("Fail at %0t ns: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic add_row(input op_e op, input logic [11:0] addr, input logic [XLEN-1:0] data,
                          input logic [XLEN-1:0] exp, input logic hold, input logic fire);
      tbl.push_back('{op, addr, data, exp, hold, fire});
   endtask

   task automatic wait_redirect(output logic seen, output logic [XLEN-1:0] tgt);
      int n;
      seen = 1'b0;
      tgt = '0;
      n = 0;
      while (!seen && n < WAIT_MAX) begin
         @(negedge clk_i);
         if (redirect_o.valid) begin
            seen = 1'b1;
            tgt = redirect_o.target;
         end
         n = n + 1;
      end
   endtask

   task automatic check_event(input int idx, input row_t r);
      logic            seen;
      logic [XLEN-1:0] tgt;
      wait_redirect(seen, tgt);
      if (r.fire) begin
         assert (seen) else report_error($sformatf("row %0d expected a redirect, none came", idx));
         assert (tgt == r.exp)
            else report_error($sformatf("row %0d redirect to 0x%08h, expected 0x%08h",
                                        idx, tgt, r.exp));
      end else begin
         assert (!seen) else report_error($sformatf("row %0d gave an unexpected redirect", idx));
      end
   endtask

   task automatic apply_row(input int idx, input row_t r);
      if (r.hold && !withhold) begin
         while (owed != 0) @(negedge clk_i);  // start holding with a full pool
      end
      withhold = r.hold;
      csr_req_i = '0;
      case (r.op)
         OP_WR: csr_req_i = '{we: 1'b1, addr: r.addr, wdata: r.data};
         OP_RD: begin
            csr_req_i.addr = r.addr;
            #10;
            assert (csr_rdata_o == r.exp)
               else report_error($sformatf("row %0d read 0x%08h, expected 0x%08h",
                                           idx, csr_rdata_o, r.exp));
         end
         OP_IRQ: begin
            pc_i = r.data;
            ext_irq_i = 1'b1;
            check_event(idx, r);
            if (!r.fire) begin
               csr_req_i.addr = CSR_MIP;
               #10;
               assert (csr_rdata_o[MIP_MEIP])
                  else report_error($sformatf("row %0d mip.MEIP clear with irq high", idx));
               @(negedge clk_i);
            end
            ext_irq_i = 1'b0;
         end
         OP_MRET: begin
            mret_i = 1'b1;
            @(negedge clk_i);
            mret_i = 1'b0;
            check_event(idx, r);
         end
         default: check_event(idx, r);  // release lets credits flow again
      endcase
      @(negedge clk_i);
      assert (!redirect_o.valid)
         else report_error($sformatf("row %0d redirect valid for more than one cycle", idx));
   endtask

   initial begin
      void'($urandom(32'hff7e_cc43));
      e_intr = 1'b1;
      csr_req_i = '0;
      pc_i = '0;
      ext_irq_i = 1'b0;
      mret_i = 1'b0;
      withhold = 1'b0;
      pc_a = $urandom() & 32'hffff_fffc;
      pc_b = $urandom() & 32'hffff_fffc;
      pc_c = $urandom() & 32'hffff_fffc;
      base_a = $urandom() & 32'hffff_fffc;
      base_b = $urandom() & 32'hffff_fffc;
      r1 = $urandom();
      r2 = $urandom();

      add_row(OP_WR, CSR_MEPC, r1, '0, 1'b0, 1'b0);
      add_row(OP_RD, CSR_MEPC, '0, r1, 1'b0, 1'b0);
      add_row(OP_WR, CSR_MCAUSE, r2, '0, 1'b0, 1'b0);
      add_row(OP_RD, CSR_MCAUSE, '0, r2, 1'b0, 1'b0);
      add_row(OP_WR, CSR_MIP, 32'hffff_ffff, '0, 1'b0, 1'b0);
      add_row(OP_RD, CSR_MIP, '0, '0, 1'b0, 1'b0);
      add_row(OP_RD, 12'h7c0, '0, '0, 1'b0, 1'b0);  // unmapped
      add_row(OP_WR, CSR_MIE, MEIE_BIT, '0, 1'b0, 1'b0);
      add_row(OP_RD, CSR_MIE, '0, MEIE_BIT, 1'b0, 1'b0);
      add_row(OP_WR, CSR_MTVEC, base_a, '0, 1'b0, 1'b0);
      add_row(OP_RD, CSR_MTVEC, '0, base_a, 1'b0, 1'b0);
      add_row(OP_WR, CSR_MSTATUS, MIE_BIT, '0, 1'b0, 1'b0);
      add_row(OP_RD, CSR_MSTATUS, '0, MIE_BIT, 1'b0, 1'b0);
      // direct mode irq and its return
      add_row(OP_IRQ, '0, pc_a, base_a, 1'b0, 1'b1);
      add_row(OP_RD, CSR_MEPC, '0, pc_a, 1'b0, 1'b0);
      add_row(OP_RD, CSR_MCAUSE, '0, EXT_CAUSE, 1'b0, 1'b0);
      add_row(OP_RD, CSR_MSTATUS, '0, MPIE_BIT, 1'b0, 1'b0);
      add_row(OP_MRET, '0, '0, pc_a, 1'b0, 1'b1);
      add_row(OP_RD, CSR_MSTATUS, '0, MIE_BIT | MPIE_BIT, 1'b0, 1'b0);
      add_row(OP_WR, CSR_MTVEC, base_b | 32'd1, '0, 1'b0, 1'b0);
      add_row(OP_IRQ, '0, pc_b, base_b + VEC_STEP, 1'b0, 1'b1);
      add_row(OP_MRET, '0, '0, pc_b, 1'b0, 1'b1);
      // masked by MIE, then by MEIE
      add_row(OP_WR, CSR_MSTATUS, '0, '0, 1'b0, 1'b0);
      add_row(OP_IRQ, '0, pc_b, '0, 1'b0, 1'b0);
      add_row(OP_WR, CSR_MSTATUS, MIE_BIT, '0, 1'b0, 1'b0);
      add_row(OP_WR, CSR_MIE, '0, '0, 1'b0, 1'b0);
      add_row(OP_IRQ, '0, pc_b, '0, 1'b0, 1'b0);
      add_row(OP_WR, CSR_MIE, MEIE_BIT, '0, 1'b0, 1'b0);
      // two credits spent and the third event waits for the release
      add_row(OP_IRQ, '0, pc_c, base_b + VEC_STEP, 1'b1, 1'b1);
      add_row(OP_MRET, '0, '0, pc_c, 1'b1, 1'b1);
      add_row(OP_MRET, '0, '0, '0, 1'b1, 1'b0);
      add_row(OP_REL, '0, '0, pc_c, 1'b0, 1'b1);
      add_row(OP_RD, CSR_MSTATUS, '0, MIE_BIT | MPIE_BIT, 1'b0, 1'b0);
      add_row(OP_RD, CSR_MEPC, '0, pc_c, 1'b0, 1'b0);

      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      e_intr = 1'b0;
      foreach (tbl[i]) begin
         apply_row(i, tbl[i]);
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire
